// File: ppu_config.svh
// register addresses, video RAM bases, line and frame timing, screen size
`ifndef PPU_CONFIG_SVH
`define PPU_CONFIG_SVH

// LCD registers in the I/O page
`define PPU_ADDR_LCDC 16'hFF40
`define PPU_ADDR_STAT 16'hFF41
`define PPU_ADDR_SCY  16'hFF42
`define PPU_ADDR_SCX  16'hFF43
`define PPU_ADDR_LY   16'hFF44
`define PPU_ADDR_LYC  16'hFF45
`define PPU_ADDR_BGP  16'hFF47

// background maps and tile data areas
`define PPU_MAP0_BASE    16'h9800
`define PPU_MAP1_BASE    16'h9C00
`define PPU_TILE_BASE_LO 16'h8000
`define PPU_TILE_BASE_HI 16'h9000

// dot and line counts
`define PPU_SCAN_DOTS     80
`define PPU_LINE_DOTS     456
`define PPU_VISIBLE_LINES 144
`define PPU_TOTAL_LINES   154

// visible pixels per line
`define PPU_SCREEN_W 160

`endif

// File: ppu_pkg.sv
// PPU package: mode and fetch-state enums, bus, config and tile-row structs
`default_nettype none

package ppu_pkg;

    // PPU modes, encoded as the STAT mode field
    typedef enum logic [1:0] {
        h_blank = 2'd0,
        v_blank = 2'd1,
        scan    = 2'd2,
        draw    = 2'd3
    } ppu_mode_e;

    // background fetcher steps
    typedef enum logic [1:0] {
        map_read  = 2'd0,
        low_read  = 2'd1,
        high_read = 2'd2,
        row_hold  = 2'd3
    } fetch_state_e;

    typedef struct packed {
        logic        wr;
        logic        rd;
        logic [15:0] addr;
        logic [7:0]  wdata;
    } mmio_req_t;

    typedef struct packed {
        logic        rd;
        logic [15:0] addr;
    } vram_req_t;

    typedef struct packed {
        logic       lcd_en;   // LCDC bit 7
        logic       map_sel;  // LCDC bit 3
        logic       tile_sel; // LCDC bit 4
        logic       bg_en;    // LCDC bit 0
        logic [7:0] scx;
        logic [7:0] scy;
        logic [7:0] bgp;
    } lcd_cfg_t;

    typedef struct packed {
        logic [7:0] low;
        logic [7:0] high;
    } tile_row_t;

endpackage

`default_nettype wire

// File: ppu_regs.sv
// ppu_regs: LCD register file, CPU read mux, STAT flags and interrupt outputs
`timescale 1ns/1ns
`default_nettype none
`include "ppu_config.svh"

module ppu_regs import ppu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  mmio_req_t  mmio,
    output logic [7:0] mmio_rdata,
    input  ppu_mode_e  mode,
    input  logic [7:0] ly,
    output lcd_cfg_t   cfg,
    output logic       irq_vblank,
    output logic       irq_stat
);

    logic [7:0] lcdc;
    logic [3:0] stat_en;     // STAT bits 6..3
    logic [7:0] scy;
    logic [7:0] scx;
    logic [7:0] lyc;
    logic [7:0] bgp;
    logic       coincidence;

    assign coincidence = (ly == lyc);

    always_ff @(posedge clk) begin
        if (rst) begin
            lcdc    <= 8'h00;  // LCD off
            stat_en <= 4'h0;
            scy     <= 8'h00;
            scx     <= 8'h00;
            lyc     <= 8'h00;
            bgp     <= 8'h00;
        end else if (mmio.wr) begin
            case (mmio.addr)
                `PPU_ADDR_LCDC: lcdc    <= mmio.wdata;
                `PPU_ADDR_STAT: stat_en <= mmio.wdata[6:3]; // low bits are status only
                `PPU_ADDR_SCY:  scy     <= mmio.wdata;
                `PPU_ADDR_SCX:  scx     <= mmio.wdata;
                `PPU_ADDR_LYC:  lyc     <= mmio.wdata;
                `PPU_ADDR_BGP:  bgp     <= mmio.wdata;
                default: ;                                  // LY and others ignore writes
            endcase
        end
    end

    always_comb begin
        mmio_rdata = 8'h00;
        if (mmio.rd) begin
            case (mmio.addr)
                `PPU_ADDR_LCDC: mmio_rdata = lcdc;
                `PPU_ADDR_STAT: mmio_rdata = {1'b1, stat_en, coincidence, mode};
                `PPU_ADDR_SCY:  mmio_rdata = scy;
                `PPU_ADDR_SCX:  mmio_rdata = scx;
                `PPU_ADDR_LY:   mmio_rdata = ly;
                `PPU_ADDR_LYC:  mmio_rdata = lyc;
                `PPU_ADDR_BGP:  mmio_rdata = bgp;
                default:        mmio_rdata = 8'hFF; // open bus
            endcase
        end
    end

    // fields the fetch and pixel pipeline works from
    always_comb begin
        cfg.lcd_en   = lcdc[7];
        cfg.map_sel  = lcdc[3];
        cfg.tile_sel = lcdc[4];
        cfg.bg_en    = lcdc[0];
        cfg.scx      = scx;
        cfg.scy      = scy;
        cfg.bgp      = bgp;
    end

    assign irq_vblank = (mode == v_blank);

    // level interrupt, any enabled STAT source
    assign irq_stat = (stat_en[3] && coincidence)
                   || (stat_en[0] && (mode == h_blank))
                   || (stat_en[1] && (mode == v_blank))
                   || (stat_en[2] && (mode == scan));

endmodule

`default_nettype wire

// File: ppu_line_timer.sv
// ppu_line_timer: dot and line counters, mode sequencing, line_start pulse
`timescale 1ns/1ns
`default_nettype none
`include "ppu_config.svh"

module ppu_line_timer import ppu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  lcd_cfg_t   cfg,
    input  logic       line_done,
    output ppu_mode_e  mode,
    output logic [7:0] ly,
    output logic       line_start
);

    logic [8:0] dot;
    logic       line_end;
    logic       frame_end;

    assign line_end  = (dot == 9'(`PPU_LINE_DOTS - 1));
    assign frame_end = (ly == 8'(`PPU_TOTAL_LINES - 1));

    always_ff @(posedge clk) begin
        if (rst || !cfg.lcd_en) begin  // LCD off holds the timer at line 0
            dot        <= 9'd0;
            ly         <= 8'd0;
            mode       <= scan;
            line_start <= 1'b0;
        end else begin
            line_start <= 1'b0;
            if (line_end) begin
                dot <= 9'd0;
                if (frame_end) begin
                    ly   <= 8'd0;
                    mode <= scan;
                end else begin
                    ly <= ly + 8'd1;
                    // next line still on screen?
                    if (ly < 8'(`PPU_VISIBLE_LINES - 1)) begin
                        mode <= scan;
                    end else begin
                        mode <= v_blank;
                    end
                end
            end else begin
                dot <= dot + 9'd1;
                case (mode)
                    scan: begin
                        if (dot == 9'(`PPU_SCAN_DOTS - 1)) begin
                            mode       <= draw;
                            line_start <= 1'b1;  // first draw dot
                        end
                    end
                    draw: begin
                        if (line_done) begin
                            mode <= h_blank;
                        end
                    end
                    default: ;                   // blanking waits for line end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: ppu_bg_fetcher.sv
// ppu_bg_fetcher: background map and tile address generation, tile row hand-off
`timescale 1ns/1ns
`default_nettype none
`include "ppu_config.svh"

module ppu_bg_fetcher import ppu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  lcd_cfg_t   cfg,
    input  logic [7:0] ly,
    input  logic       line_start,
    output vram_req_t  vram,
    input  logic [7:0] vram_rdata,
    output tile_row_t  row,
    output logic       row_valid,
    input  logic       row_ready
);

    localparam logic [4:0] cols_per_line = 5'd21;  // 20 on screen plus one for fine scroll

    fetch_state_e state;
    logic [4:0]   col;        // next map column to read
    logic [7:0]   tile_q;
    logic [7:0]   low_q;
    logic [7:0]   high_q;
    logic         row_full;
    logic         high_live;  // high byte still on the bus
    logic [7:0]   line_y;
    logic [4:0]   map_x;
    logic [15:0]  map_addr;
    logic [7:0]   rdata_bg;
    logic         xfer;
    logic         more_cols;

    function automatic logic [15:0] tile_addr(input logic       sel,
                                              input logic [7:0] num,
                                              input logic [2:0] fine_y,
                                              input logic       hi);
        logic [15:0] base;
        if (sel) begin
            base = `PPU_TILE_BASE_LO + {4'b0, num, 4'b0};
        end else begin
            base = `PPU_TILE_BASE_HI + {{4{num[7]}}, num, 4'b0}; // signed tile number
        end
        return base + {12'b0, fine_y, hi};
    endfunction

    assign line_y    = ly + cfg.scy;             // wraps at 256
    assign map_x     = cfg.scx[7:3] + col;       // wraps at 32
    assign map_addr  = (cfg.map_sel ? `PPU_MAP1_BASE : `PPU_MAP0_BASE)
                     + {6'b0, line_y[7:3], map_x};
    assign rdata_bg  = cfg.bg_en ? vram_rdata : 8'h00;
    assign xfer      = row_valid && row_ready;
    assign more_cols = (col != cols_per_line);

    assign row_valid = (state == row_hold) && row_full;
    assign row.low   = low_q;
    assign row.high  = high_live ? rdata_bg : high_q;

    always_comb begin
        vram.rd   = 1'b0;
        vram.addr = map_addr;
        case (state)
            map_read: vram.rd = 1'b1;
            low_read: begin
                vram.rd   = 1'b1;
                vram.addr = tile_addr(cfg.tile_sel, vram_rdata, line_y[2:0], 1'b0);
            end
            high_read: begin
                vram.rd   = 1'b1;
                vram.addr = tile_addr(cfg.tile_sel, tile_q, line_y[2:0], 1'b1);
            end
            row_hold: vram.rd = xfer && more_cols; // next map read in the hand-off cycle
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= row_hold;
            col       <= 5'd0;
            row_full  <= 1'b0;
            high_live <= 1'b0;
        end else if (line_start) begin
            state     <= map_read;
            col       <= 5'd0;
            row_full  <= 1'b0;
            high_live <= 1'b0;
        end else begin
            high_live <= 1'b0;
            case (state)
                map_read: begin
                    state <= low_read;
                    col   <= col + 5'd1;
                end
                low_read:  state <= high_read;
                high_read: begin
                    state     <= row_hold;
                    row_full  <= 1'b1;
                    high_live <= 1'b1;
                end
                default: begin                      // row_hold
                    if (xfer) begin
                        row_full <= 1'b0;
                        if (more_cols) begin
                            state <= low_read;
                            col   <= col + 5'd1;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == low_read) begin
            tile_q <= vram_rdata;
        end
        if (state == high_read) begin
            low_q <= rdata_bg;
        end
        if (high_live) begin
            high_q <= rdata_bg;  // keeps the row stable under back-pressure
        end
    end

endmodule

`default_nettype wire

// File: ppu_pixel_queue.sv
// ppu_pixel_queue: tile row shifter, fine scroll drop, palette map, line pixel count
`timescale 1ns/1ns
`default_nettype none
`include "ppu_config.svh"

module ppu_pixel_queue import ppu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  lcd_cfg_t   cfg,
    input  logic       line_start,
    input  tile_row_t  row,
    input  logic       row_valid,
    output logic       row_ready,
    output logic [1:0] px,
    output logic       px_valid,
    output logic       line_done
);

    logic [7:0] lo_sr;
    logic [7:0] hi_sr;
    logic [3:0] cnt;     // pixels left in the pair
    logic [2:0] drop;    // fine scroll pixels still to discard
    logic [7:0] px_cnt;
    logic       active;
    logic [1:0] idx;
    logic       load;
    logic       last_px;

    assign row_ready = active && (cnt <= 4'd1);
    assign load      = row_valid && row_ready;
    assign idx       = {hi_sr[7], lo_sr[7]};
    assign px_valid  = active && (cnt != 4'd0) && (drop == 3'd0);
    assign px        = cfg.bgp[{idx, 1'b0} +: 2];   // BGP shade lookup
    assign last_px   = px_valid && (px_cnt == 8'(`PPU_SCREEN_W - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            active    <= 1'b0;
            cnt       <= 4'd0;
            drop      <= 3'd0;
            px_cnt    <= 8'd0;
            line_done <= 1'b0;
        end else begin
            line_done <= last_px;
            if (line_start) begin
                active <= 1'b1;
                cnt    <= 4'd0;
                drop   <= cfg.scx[2:0];
                px_cnt <= 8'd0;
            end else begin
                if (load) begin
                    cnt <= 4'd8;
                end else if (cnt != 4'd0) begin
                    cnt <= cnt - 4'd1;
                end
                if ((cnt != 4'd0) && (drop != 3'd0)) begin
                    drop <= drop - 3'd1;
                end
                if (px_valid) begin
                    px_cnt <= px_cnt + 8'd1;
                end
                if (last_px) begin
                    active <= 1'b0;                // line complete
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            lo_sr <= row.low;
            hi_sr <= row.high;
        end else begin
            lo_sr <= {lo_sr[6:0], 1'b0};           // MSB is the leftmost pixel
            hi_sr <= {hi_sr[6:0], 1'b0};
        end
    end

endmodule

`default_nettype wire

// File: ppu_top.sv
// ppu_top: background PPU with register file, line timer, fetcher and pixel queue
`timescale 1ns/1ns
`default_nettype none

module ppu_top import ppu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  mmio_req_t  mmio,
    output logic [7:0] mmio_rdata,
    output vram_req_t  vram,
    input  logic [7:0] vram_rdata,
    output logic [1:0] px,
    output logic       px_valid,
    output ppu_mode_e  mode,
    output logic       irq_vblank,
    output logic       irq_stat
);

    lcd_cfg_t   cfg;
    logic [7:0] ly;
    logic       line_start;
    logic       line_done;
    tile_row_t  row;
    logic       row_valid;
    logic       row_ready;

    ppu_regs u_regs (
        .clk        (clk),
        .rst        (rst),
        .mmio       (mmio),
        .mmio_rdata (mmio_rdata),
        .mode       (mode),
        .ly         (ly),
        .cfg        (cfg),
        .irq_vblank (irq_vblank),
        .irq_stat   (irq_stat)
    );

    ppu_line_timer u_timer (
        .clk        (clk),
        .rst        (rst),
        .cfg        (cfg),
        .line_done  (line_done),
        .mode       (mode),
        .ly         (ly),
        .line_start (line_start)
    );

    ppu_bg_fetcher u_fetcher (
        .clk        (clk),
        .rst        (rst),
        .cfg        (cfg),
        .ly         (ly),
        .line_start (line_start),
        .vram       (vram),
        .vram_rdata (vram_rdata),
        .row        (row),
        .row_valid  (row_valid),
        .row_ready  (row_ready)
    );

    ppu_pixel_queue u_queue (
        .clk        (clk),
        .rst        (rst),
        .cfg        (cfg),
        .line_start (line_start),
        .row        (row),
        .row_valid  (row_valid),
        .row_ready  (row_ready),
        .px         (px),
        .px_valid   (px_valid),
        .line_done  (line_done)
    );

endmodule

`default_nettype wire

// File: tb_ppu.sv
// testbench with video RAM model, pixel reference, compare tasks and watchdog
`timescale 1ns/1ns
`default_nettype none
`include "ppu_config.svh"

module tb_ppu import ppu_pkg::*; ();

    localparam int frame_cycles = `PPU_LINE_DOTS * `PPU_TOTAL_LINES;
    localparam int limit_cycles = 3 * frame_cycles + 20 * `PPU_LINE_DOTS;

    logic       clk;
    logic       rst;
    mmio_req_t  mmio;
    logic [7:0] mmio_rdata;
    vram_req_t  vram;
    logic [7:0] vram_rdata;
    logic [1:0] px;
    logic       px_valid;
    ppu_mode_e  mode;
    logic       irq_vblank;
    logic       irq_stat;

    logic [7:0]  vram_mem [0:65535];
    logic        rd_pend;
    logic [15:0] addr_pend;
    logic [7:0]  cfg_lcdc, cfg_scx, cfg_scy, cfg_bgp;  // register values the DUT holds
    int          vis_line, cur_line, px_x;
    ppu_mode_e   prev_mode;
    int          run, line, match_cycles;
    logic [7:0]  rd_v, wr_v, lyc_v, prev_ly;
    logic        first_line, wrapped, match;
    ppu_mode_e   prev_m;
    int          i;

    ppu_top uut (
        .clk        (clk),
        .rst        (rst),
        .mmio       (mmio),
        .mmio_rdata (mmio_rdata),
        .vram       (vram),
        .vram_rdata (vram_rdata),
        .px         (px),
        .px_valid   (px_valid),
        .mode       (mode),
        .irq_vblank (irq_vblank),
        .irq_stat   (irq_stat)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // video RAM answers in the cycle after the read
    always @(negedge clk) begin
        rd_pend   <= vram.rd;
        addr_pend <= vram.addr;
    end

    always @(posedge clk) begin
        #10;
        if (rd_pend === 1'b1) begin
            vram_rdata = vram_mem[addr_pend];
        end
    end

    task automatic abort_run(input string what);
        $display("%0t ns: %s", $time, what);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s = %02h, expected %02h", $time, name, got, exp);
            abort_run("register value mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
            abort_run("flag mismatch");
        end
    endtask

    task automatic check_mode(input string name, input ppu_mode_e got, input ppu_mode_e exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s = %s, expected %s", $time, name, got.name(),
                     exp.name());
            abort_run("mode mismatch");
        end
    endtask

    task automatic check_px(input string name, input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s = %0d, expected %0d (line %0d, x %0d)",
                     $time, name, got, exp, cur_line, px_x);
            abort_run("pixel mismatch");
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("** Error at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
            abort_run("count mismatch");
        end
    endtask

    task automatic reg_write(input logic [15:0] addr, input logic [7:0] data);
        @(posedge clk);
        #10;
        mmio.wr    = 1'b1;
        mmio.rd    = 1'b0;
        mmio.addr  = addr;
        mmio.wdata = data;
        @(posedge clk);
        #10;
        mmio.wr = 1'b0;
        case (addr)
            `PPU_ADDR_LCDC: cfg_lcdc = data;
            `PPU_ADDR_SCX:  cfg_scx  = data;
            `PPU_ADDR_SCY:  cfg_scy  = data;
            `PPU_ADDR_BGP:  cfg_bgp  = data;
            default: ;
        endcase
    endtask

    task automatic reg_read(input logic [15:0] addr, output logic [7:0] data);
        @(posedge clk);
        #10;
        mmio.rd   = 1'b1;
        mmio.addr = addr;
        @(negedge clk);
        data = mmio_rdata;  // combinational read path
        @(posedge clk);
        #10;
        mmio.rd = 1'b0;
    endtask

    task automatic wait_for_mode(input ppu_mode_e m);
        do @(negedge clk); while (mode != m);
    endtask

    // shade of screen pixel x on a line, straight from map, tile data and palette
    function automatic logic [1:0] ref_shade(input int x, input int ln, input logic [7:0] lcdc,
                                             input logic [7:0] scx, input logic [7:0] scy,
                                             input logic [7:0] bgp);
        int         ypos, xpos, map_addr, data_addr, bit_pos;
        logic [7:0] tile_num, lo, hi;
        logic [1:0] colour;
        ypos     = (ln + scy) % 256;
        xpos     = (x + scx) % 256;
        map_addr = (lcdc[3] ? `PPU_MAP1_BASE : `PPU_MAP0_BASE) + 32 * (ypos / 8) + xpos / 8;
        tile_num = vram_mem[map_addr];
        if (lcdc[4]) begin
            data_addr = `PPU_TILE_BASE_LO + 16 * int'(tile_num);
        end else begin
            data_addr = `PPU_TILE_BASE_HI + 16 * int'($signed(tile_num));
        end
        data_addr = data_addr + 2 * (ypos % 8);
        lo        = vram_mem[data_addr];
        hi        = vram_mem[data_addr + 1];
        bit_pos   = 7 - xpos % 8;           // leftmost pixel in bit 7
        colour    = {hi[bit_pos], lo[bit_pos]};
        if (!lcdc[0]) begin
            colour = 2'd0;
        end
        return bgp[2 * colour +: 2];
    endfunction

    // pixel and line checks sampled mid-cycle
    always @(negedge clk) begin
        if (!rst) begin
            if (!cfg_lcdc[7]) begin
                vis_line = 0;
            end else begin
                if (px_valid) begin
                    if (mode != draw) abort_run("pixel output outside draw mode");
                    if (px_x >= `PPU_SCREEN_W) abort_run("more than 160 pixels on a line");
                    check_px("px", px, ref_shade(px_x, cur_line, cfg_lcdc, cfg_scx, cfg_scy,
                                                 cfg_bgp));
                    px_x++;
                end
                if (mode == draw && prev_mode != draw) begin
                    cur_line = vis_line;
                    vis_line++;
                    px_x = 0;
                end
                if (mode != draw && prev_mode == draw) begin
                    check_count("pixels per line", px_x, `PPU_SCREEN_W);
                    check_mode("mode after draw", mode, h_blank);
                end
                if (mode == v_blank && prev_mode != v_blank) begin
                    check_count("visible lines", vis_line, `PPU_VISIBLE_LINES);
                end
            end
            prev_mode = mode;
        end
    end

    initial begin
        #(limit_cycles * 100);
        abort_run("watchdog expired before the tests finished");
    end

    initial begin
        rst         = 1'b1;
        mmio        = '0;
        vram_rdata  = 8'h00;
        cfg_lcdc    = 8'h00;
        cfg_scx     = 8'h00;
        cfg_scy     = 8'h00;
        cfg_bgp     = 8'h00;
        vis_line    = 0;
        cur_line    = 0;
        px_x        = 0;
        prev_mode   = scan;
        i           = $urandom(21642);
        for (i = 0; i < 65536; i++) begin
            vram_mem[i] = 8'($urandom);
        end
        repeat (16) @(posedge clk);
        #10;
        rst = 1'b0;

        // reset values and register access
        @(negedge clk);
        check_flag("px_valid", px_valid, 1'b0);
        check_flag("vram.rd", vram.rd, 1'b0);
        check_flag("irq_vblank", irq_vblank, 1'b0);
        check_flag("irq_stat", irq_stat, 1'b0);
        reg_read(`PPU_ADDR_LY, rd_v);
        check_byte("LY", rd_v, 8'h00);
        wr_v = 8'($urandom);
        reg_write(`PPU_ADDR_SCY, wr_v);
        reg_read(`PPU_ADDR_SCY, rd_v);
        check_byte("SCY", rd_v, wr_v);
        wr_v = 8'($urandom);
        reg_write(`PPU_ADDR_SCX, wr_v);
        reg_read(`PPU_ADDR_SCX, rd_v);
        check_byte("SCX", rd_v, wr_v);
        lyc_v = 8'($urandom);
        reg_write(`PPU_ADDR_LYC, lyc_v);
        reg_read(`PPU_ADDR_LYC, rd_v);
        check_byte("LYC", rd_v, lyc_v);
        wr_v = 8'($urandom);
        reg_write(`PPU_ADDR_BGP, wr_v);
        reg_read(`PPU_ADDR_BGP, rd_v);
        check_byte("BGP", rd_v, wr_v);
        wr_v = 8'($urandom);
        reg_write(`PPU_ADDR_STAT, wr_v);
        reg_read(`PPU_ADDR_STAT, rd_v);
        check_byte("STAT", rd_v, {1'b1, wr_v[6:3], lyc_v == 8'd0, scan}); // LCD off, line 0
        reg_write(`PPU_ADDR_LY, 8'($urandom));
        reg_read(`PPU_ADDR_LY, rd_v);
        check_byte("LY", rd_v, 8'h00);
        reg_read(16'hFF46, rd_v);
        check_byte("unmapped FF46", rd_v, 8'hFF);
        reg_read({1'b0, 15'($urandom)}, rd_v);
        check_byte("unmapped low address", rd_v, 8'hFF);
        wr_v = 8'($urandom);
        reg_write(`PPU_ADDR_LCDC, wr_v);
        reg_read(`PPU_ADDR_LCDC, rd_v);
        check_byte("LCDC", rd_v, wr_v);
        reg_write(`PPU_ADDR_LCDC, 8'h00);
        reg_write(`PPU_ADDR_STAT, 8'h00);

        // frame timing with pixels checked alongside
        reg_write(`PPU_ADDR_SCX, 8'($urandom));
        reg_write(`PPU_ADDR_SCY, 8'($urandom));
        reg_write(`PPU_ADDR_BGP, 8'($urandom));
        reg_write(`PPU_ADDR_LCDC, 8'h81 | (8'($urandom) & 8'h18));
        mmio.rd    = 1'b1;
        mmio.addr  = `PPU_ADDR_LY;
        first_line = 1'b1;
        wrapped    = 1'b0;
        run        = 0;
        prev_ly    = 8'd0;
        while (!wrapped) begin
            @(negedge clk);
            rd_v = mmio_rdata;
            if (rd_v != prev_ly) begin
                check_byte("LY", rd_v,
                           (prev_ly == 8'(`PPU_TOTAL_LINES - 1)) ? 8'd0 : prev_ly + 8'd1);
                if (!first_line) check_count("line length", run, `PPU_LINE_DOTS);
                wrapped    = (rd_v == 8'd0);
                first_line = 1'b0;
                run        = 0;
                prev_ly    = rd_v;
            end
            if (!first_line && rd_v < `PPU_VISIBLE_LINES) begin
                if (run < `PPU_SCAN_DOTS) check_mode("mode", mode, scan);
                else if (run == `PPU_SCAN_DOTS) check_mode("mode", mode, draw);
                else if (run == `PPU_LINE_DOTS - 1) check_mode("mode", mode, h_blank);
            end else if (!first_line) begin
                check_mode("mode", mode, v_blank);
            end
            check_flag("irq_vblank", irq_vblank, rd_v >= `PPU_VISIBLE_LINES);
            run++;
        end
        reg_write(`PPU_ADDR_LCDC, 8'h00);  // still in scan of line 0

        // second random background
        reg_write(`PPU_ADDR_SCX, 8'($urandom));
        reg_write(`PPU_ADDR_SCY, 8'($urandom));
        reg_write(`PPU_ADDR_BGP, 8'($urandom));
        reg_write(`PPU_ADDR_LCDC, 8'h81 | (8'($urandom) & 8'h18));
        wait_for_mode(v_blank);
        reg_write(`PPU_ADDR_LCDC, 8'h00);

        // background off and LY coincidence interrupt
        lyc_v = 8'(1 + $urandom % (`PPU_VISIBLE_LINES - 1));
        reg_write(`PPU_ADDR_LYC, lyc_v);
        reg_write(`PPU_ADDR_STAT, 8'h40);
        reg_write(`PPU_ADDR_BGP, 8'($urandom));
        reg_write(`PPU_ADDR_LCDC, 8'h80 | (8'($urandom) & 8'h18));
        mmio.rd      = 1'b1;
        mmio.addr    = `PPU_ADDR_STAT;
        line         = 0;
        prev_m       = scan;
        match_cycles = 0;
        do begin
            @(negedge clk);
            rd_v = mmio_rdata;
            if (mode != prev_m && (mode == scan || mode == v_blank)) line++;
            match = (line == lyc_v);
            check_byte("STAT", rd_v & 8'hFC, {1'b1, 4'b1000, match, 2'b00});
            check_mode("STAT mode", ppu_mode_e'(rd_v[1:0]), mode);
            check_flag("irq_stat", irq_stat, match);
            if (match) match_cycles++;
            prev_m = mode;
        end while (mode != v_blank);
        check_count("coincidence cycles", match_cycles, `PPU_LINE_DOTS);
        reg_write(`PPU_ADDR_LCDC, 8'h00);

        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+.
ppu_pkg.sv
ppu_regs.sv
ppu_line_timer.sv
ppu_bg_fetcher.sv
ppu_pixel_queue.sv
ppu_top.sv
tb_ppu.sv

// File: Bender.yml
package:
  name: ppu_bg

sources:
  - include_dirs:
      - .
    files:
      - ppu_pkg.sv
      - ppu_regs.sv
      - ppu_line_timer.sv
      - ppu_bg_fetcher.sv
      - ppu_pixel_queue.sv
      - ppu_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_ppu.sv
